/* src/cmd_pkg.sv */
package cmd_pkg;

    // --------------------------------------------------
    // Widths and depths
    // --------------------------------------------------
    localparam int data_width     = 16;
    localparam int seq_width      = 8;
    localparam int cmd_fifo_depth = 8;
    localparam int res_fifo_depth = 4;

    // Command FIFO fill count wide enough to hold the full depth
    localparam int cmd_cnt_width  = $clog2(cmd_fifo_depth) + 1;

    // --------------------------------------------------
    // Enumerations
    // --------------------------------------------------
    // Codes 8 to 15 are not listed and count as illegal
    typedef enum logic [3:0] {
        op_add = 4'd0,
        op_sub = 4'd1,
        op_and = 4'd2,
        op_or  = 4'd3,
        op_xor = 4'd4,
        op_shl = 4'd5,
        op_shr = 4'd6,
        op_max = 4'd7
    } opcode_e;

    typedef enum logic {
        st_ok      = 1'b0,
        st_illegal = 1'b1
    } status_e;

    // --------------------------------------------------
    // Payload structs
    // --------------------------------------------------
    // Raw command as it arrives on the input port
    typedef struct packed {
        logic [3:0]            opcode;
        logic [data_width-1:0] operand_a;
        logic [data_width-1:0] operand_b;
    } cmd_t;

    // Decoded command handed to the execute stage
    typedef struct packed {
        opcode_e               op;
        logic                  illegal;
        logic [data_width-1:0] operand_a;
        logic [data_width-1:0] operand_b;
    } dec_t;

    // ALU outcome
    typedef struct packed {
        logic [data_width-1:0] value;
        logic                  illegal;
        logic                  zero;
    } exe_t;

    // Result word written into the result FIFO
    typedef struct packed {
        logic [seq_width-1:0]  seq;
        status_e               status;
        logic                  zero;
        logic [data_width-1:0] value;
    } res_t;

endpackage : cmd_pkg

/* src/fifo_sync.sv */
`timescale 1ns/1ps

// DEPTH must be a power of two so the pointers wrap on their own
module fifo_sync #(
    parameter type DATA_T = logic [15:0],
    parameter int  DEPTH  = 8
) (
    input  logic                 clk,
    input  logic                 rst_n,

    // Write side
    output logic                 wr_rdy,
    input  logic                 wr,
    input  DATA_T                wr_data,
    output logic [$clog2(DEPTH):0] wr_count,
    output logic                 full,

    // First-word-fall-through read side
    input  logic                 rd,
    output logic                 rd_ack,
    output DATA_T                rd_data,
    output logic [$clog2(DEPTH):0] rd_count,
    output logic                 empty
);

    localparam int addr_width = $clog2(DEPTH);

    // --------------------------------------------------
    // Storage and pointers
    // --------------------------------------------------
    DATA_T                 mem [DEPTH];
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic [addr_width:0]   count;

    logic                  do_wr;
    logic                  do_rd;

    // Status from occupancy
    assign full   = (count == DEPTH[addr_width:0]);
    assign empty  = (count == '0);
    assign wr_rdy = ~full;

    // Qualified strobes
    assign do_wr  = wr & ~full;
    assign do_rd  = rd & ~empty;
    assign rd_ack = do_rd;

    // --------------------------------------------------
    // Pointer and occupancy update
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // --------------------------------------------------
    // Array write
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Head entry shown combinationally
    assign rd_data = mem[rd_ptr];

    // Both sides see the same clock, so one count serves both
    assign wr_count = count;
    assign rd_count = count;

endmodule : fifo_sync

/* src/cmd_decode.sv */
`timescale 1ns/1ps

module cmd_decode
    import cmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // Command FIFO read side
    input  logic fifo_empty,
    input  cmd_t fifo_data,
    output logic fifo_rd,

    // Toward the execute stage
    output logic dec_valid,
    output dec_t dec_out,
    input  logic dec_ready
);

    logic accept;
    logic illegal;
    dec_t dec_next;

    // --------------------------------------------------
    // Flow control
    // --------------------------------------------------
    // Register is free, or its contents leave this cycle
    assign accept  = ~dec_valid | dec_ready;
    assign fifo_rd = accept & ~fifo_empty;

    // --------------------------------------------------
    // Opcode check
    // --------------------------------------------------
    // Only codes 0 to 7 are defined, so the top bit flags an illegal code
    assign illegal = fifo_data.opcode[3];

    always_comb begin
        dec_next.illegal = illegal;
        if (illegal) begin
            dec_next.op        = op_add;
            dec_next.operand_a = '0;
            dec_next.operand_b = '0;
        end else begin
            dec_next.op        = opcode_e'(fifo_data.opcode);
            dec_next.operand_a = fifo_data.operand_a;
            dec_next.operand_b = fifo_data.operand_b;
        end
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (accept) begin
            dec_valid <= ~fifo_empty;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            dec_out <= dec_next;
        end
    end

endmodule : cmd_decode

/* src/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute
    import cmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // From the decode stage
    input  logic dec_valid,
    input  dec_t dec_in,
    output logic dec_ready,

    // Toward the result stage
    output logic exe_valid,
    output exe_t exe_out,
    input  logic exe_ready
);

    logic                  take;
    logic [data_width-1:0] alu_value;
    logic [3:0]            shamt;

    assign dec_ready = ~exe_valid | exe_ready;
    assign take      = dec_valid & dec_ready;

    // Shifts only use the low nibble of operand_b
    assign shamt = dec_in.operand_b[3:0];

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        if (dec_in.illegal) begin
            alu_value = '0;
        end else begin
            case (dec_in.op)
                op_add:  alu_value = dec_in.operand_a + dec_in.operand_b;
                op_sub:  alu_value = dec_in.operand_a - dec_in.operand_b;
                op_and:  alu_value = dec_in.operand_a & dec_in.operand_b;
                op_or:   alu_value = dec_in.operand_a | dec_in.operand_b;
                op_xor:  alu_value = dec_in.operand_a ^ dec_in.operand_b;
                op_shl:  alu_value = dec_in.operand_a << shamt;
                op_shr:  alu_value = dec_in.operand_a >> shamt;
                op_max: begin
                    // Unsigned compare
                    alu_value = (dec_in.operand_a > dec_in.operand_b) ?
                                dec_in.operand_a : dec_in.operand_b;
                end
                default: alu_value = '0;
            endcase
        end
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else if (dec_ready) begin
            exe_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            exe_out.value   <= alu_value;
            exe_out.illegal <= dec_in.illegal;
            exe_out.zero    <= (alu_value == '0);
        end
    end

endmodule : alu_execute

/* src/result_pack.sv */
`timescale 1ns/1ps

module result_pack
    import cmd_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    // From the execute stage
    input  logic exe_valid,
    input  exe_t exe_in,
    output logic exe_ready,

    // Result FIFO write side
    output logic res_wr,
    output res_t res_data,
    input  logic res_rdy
);

    logic                 take;
    logic [seq_width-1:0] seq_cnt;

    // Write is held until the FIFO takes it
    assign exe_ready = ~res_wr | res_rdy;
    assign take      = exe_valid & exe_ready;

    // --------------------------------------------------
    // Control and sequence counter
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_wr  <= 1'b0;
            seq_cnt <= '0;
        end else begin
            if (exe_ready) begin
                res_wr <= exe_valid;
            end
            // Wraps from 255 back to 0
            if (take) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Result word
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            res_data.seq    <= seq_cnt;
            res_data.status <= exe_in.illegal ? st_illegal : st_ok;
            res_data.zero   <= exe_in.zero;
            res_data.value  <= exe_in.value;
        end
    end

endmodule : result_pack

/* src/cmd_engine_top.sv */
`timescale 1ns/1ps

module cmd_engine_top
    import cmd_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    // Command input
    input  logic                     in_valid,
    output logic                     in_ready,
    input  cmd_t                     in_cmd,

    // Result output
    output logic                     out_valid,
    input  logic                     out_ready,
    output res_t                     out_res,

    output logic [cmd_cnt_width-1:0] cmd_count
);

    // --------------------------------------------------
    // Stage wiring
    // --------------------------------------------------
    logic cmd_empty;
    cmd_t cmd_head;
    logic cmd_rd;

    logic dec_valid;
    dec_t dec_data;
    logic dec_ready;

    logic exe_valid;
    exe_t exe_data;
    logic exe_ready;

    logic res_wr;
    res_t res_data;
    logic res_rdy;
    logic res_empty;

    // Command queue
    fifo_sync #(
        .DATA_T (cmd_t),
        .DEPTH  (cmd_fifo_depth)
    ) u_cmd_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_rdy   (in_ready),
        .wr       (in_valid),
        .wr_data  (in_cmd),
        .wr_count (cmd_count),
        .full     (),
        .rd       (cmd_rd),
        .rd_ack   (),
        .rd_data  (cmd_head),
        .rd_count (),
        .empty    (cmd_empty)
    );

    cmd_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (cmd_empty),
        .fifo_data  (cmd_head),
        .fifo_rd    (cmd_rd),
        .dec_valid  (dec_valid),
        .dec_out    (dec_data),
        .dec_ready  (dec_ready)
    );

    alu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec_in    (dec_data),
        .dec_ready (dec_ready),
        .exe_valid (exe_valid),
        .exe_out   (exe_data),
        .exe_ready (exe_ready)
    );

    result_pack u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .exe_valid (exe_valid),
        .exe_in    (exe_data),
        .exe_ready (exe_ready),
        .res_wr    (res_wr),
        .res_data  (res_data),
        .res_rdy   (res_rdy)
    );

    // Result queue whose head drives the output port
    fifo_sync #(
        .DATA_T (res_t),
        .DEPTH  (res_fifo_depth)
    ) u_res_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_rdy   (res_rdy),
        .wr       (res_wr),
        .wr_data  (res_data),
        .wr_count (),
        .full     (),
        .rd       (out_ready),
        .rd_ack   (),
        .rd_data  (out_res),
        .rd_count (),
        .empty    (res_empty)
    );

    assign out_valid = ~res_empty;

endmodule : cmd_engine_top

/* sim/cmd_engine_assert.sv */
`timescale 1ns/1ps

module cmd_engine_assert
    import cmd_pkg::*;
(
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_ready,
    input logic                     out_valid,
    input logic                     out_ready,
    input res_t                     out_res,
    input logic [cmd_cnt_width-1:0] cmd_count
);

    // Count of failed checks
    int unsigned fail_count = 0;

    // --------------------------------------------------
    // Output handshake
    // --------------------------------------------------
    // A stalled result must hold until taken
    out_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_res)))
        else begin
            $error("out_valid or out_res changed while out_ready was low");
            fail_count++;
        end

    out_idle_after_reset_a: assert property (@(posedge clk)
        $rose(rst_n) |-> !out_valid)
        else begin
            $error("out_valid high in the first cycle after reset");
            fail_count++;
        end

    // --------------------------------------------------
    // Command FIFO fill
    // --------------------------------------------------
    cmd_count_bound_a: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_count <= cmd_fifo_depth)
        else begin
            $error("cmd_count above the command FIFO depth");
            fail_count++;
        end

    in_ready_full_a: assert property (@(posedge clk) disable iff (!rst_n)
        !in_ready == (cmd_count == cmd_fifo_depth))
        else begin
            $error("in_ready does not match the command FIFO fill");
            fail_count++;
        end

endmodule : cmd_engine_assert

bind cmd_engine_top cmd_engine_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res),
    .cmd_count (cmd_count)
);

/* sim/tb_cmd_engine.sv */
`timescale 1ns/1ps

module tb_cmd_engine
    import cmd_pkg::*;
;

    localparam int num_cmds    = 300;
    localparam int hold_cycles = 60;
    localparam int stall_limit = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    logic                     in_ready;
    cmd_t                     in_cmd;
    logic                     out_valid;
    logic                     out_ready;
    res_t                     out_res;
    logic [cmd_cnt_width-1:0] cmd_count;

    logic                     in_fire;
    logic                     out_fire;
    logic                     saw_full;
    logic [seq_width-1:0]     seq_next;
    logic [15:0]              lfsr_state;
    res_t                     exp_q[$];

    cmd_engine_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp) else stop_with_failure($sformatf(
            "CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got));
    endtask

    // Galois LFSR stepped once per bit handed out
    function automatic logic [15:0] lfsr_bits(input int n);
        logic [15:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 16'hB400;
            end
            v = {v[14:0], lsb};
        end
        return v;
    endfunction

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic res_t expect_result(input cmd_t cmd, input logic [7:0] seq);
        res_t        r;
        logic [15:0] a;
        logic [15:0] b;
        a        = cmd.operand_a;
        b        = cmd.operand_b;
        r.seq    = seq;
        r.status = st_ok;
        case (cmd.opcode)
            4'd0:    r.value = a + b;
            4'd1:    r.value = a - b;
            4'd2:    r.value = a & b;
            4'd3:    r.value = a | b;
            4'd4:    r.value = a ^ b;
            4'd5:    r.value = a << b[3:0];
            4'd6:    r.value = a >> b[3:0];
            4'd7:    r.value = (a >= b) ? a : b;
            default: begin
                r.value  = '0;
                r.status = st_illegal;
            end
        endcase
        r.zero = (r.value == 16'h0000);
        return r;
    endfunction

    // Edge cases first and random traffic after
    function automatic cmd_t next_cmd(input int idx);
        case (idx)
            0:       return '{4'd0, 16'h1234, 16'h0F0F};
            1:       return '{4'd1, 16'h5555, 16'h5555};
            2:       return '{4'd2, 16'hF0F0, 16'h0F0F};
            3:       return '{4'd3, 16'hA500, 16'h005A};
            4:       return '{4'd4, 16'hFFFF, 16'h0F0F};
            5:       return '{4'd5, 16'h8001, 16'h0000};
            6:       return '{4'd5, 16'h0003, 16'h000F};
            7:       return '{4'd6, 16'h8001, 16'h001F};
            8:       return '{4'd7, 16'h7777, 16'h7777};
            9:       return '{4'd7, 16'h0010, 16'hFFF0};
            10:      return '{4'd8, 16'hDEAD, 16'hBEEF};
            11:      return '{4'd15, 16'h1111, 16'h2222};
            12:      return '{4'd0, 16'hFFFF, 16'h0001};
            13:      return '{4'd6, 16'h4321, 16'h0010};
            default: return '{lfsr_bits(4), lfsr_bits(16), lfsr_bits(16)};
        endcase
    endfunction

    task automatic compare_output();
        res_t exp;
        if (exp_q.size() == 0) begin
            stop_with_failure("A result appeared on the output with no command pending");
        end else begin
            exp = exp_q.pop_front();
            check_field("out_res.seq", out_res.seq, exp.seq);
            check_field("out_res.status", out_res.status, exp.status);
            check_field("out_res.zero", out_res.zero, exp.zero);
            check_field("out_res.value", out_res.value, exp.value);
        end
    endtask

    // --------------------------------------------------
    // Monitor sampled away from the active edge
    // --------------------------------------------------
    always @(negedge clk) begin
        if (dut0.u_assert.fail_count != 0) begin
            stop_with_failure("A protocol assertion bound into the engine failed");
        end
        in_fire  = rst_n && in_valid && in_ready;
        out_fire = rst_n && out_valid && out_ready;
        if (rst_n && cmd_count == cmd_fifo_depth && !in_ready) begin
            saw_full = 1'b1;
        end
        if (out_fire) begin
            compare_output();
        end
        if (in_fire) begin
            exp_q.push_back(expect_result(in_cmd, seq_next));
            seq_next = seq_next + 1'b1;
        end
    end

    initial begin : stimulus
        int sent;
        int cycle;
        int stall;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_cmd     = '0;
        out_ready  = 1'b0;
        in_fire    = 1'b0;
        out_fire   = 1'b0;
        saw_full   = 1'b0;
        seq_next   = '0;
        lfsr_state = 16'd24461;
        sent       = 0;
        cycle      = 0;
        stall      = 0;
        repeat (16) @(posedge clk);
        #1;
        check_field("out_valid", out_valid, 1'b0);
        check_field("in_ready", in_ready, 1'b1);
        check_field("cmd_count", cmd_count, '0);
        rst_n = 1'b1;

        // Output held off at first so both FIFOs fill
        while ((sent < num_cmds || exp_q.size() != 0) && stall <= stall_limit) begin
            @(posedge clk);
            #1;
            cycle++;
            stall = (in_fire || out_fire) ? 0 : stall + 1;
            if (in_fire) begin
                in_valid = 1'b0;
                sent++;
            end
            if (!in_valid && sent < num_cmds && lfsr_bits(2) != 0) begin
                in_cmd   = next_cmd(sent);
                in_valid = 1'b1;
            end
            out_ready = (cycle >= hold_cycles) && (lfsr_bits(2) != 0);
        end

        if (stall > stall_limit) begin
            stop_with_failure("Timed out with no transfer on either side of the engine");
        end else if (!saw_full) begin
            stop_with_failure("The command FIFO never filled while the output was held off");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule : tb_cmd_engine

/* verilog.f */
src/cmd_pkg.sv
src/fifo_sync.sv
src/cmd_decode.sv
src/alu_execute.sv
src/result_pack.sv
src/cmd_engine_top.sv
sim/cmd_engine_assert.sv
sim/tb_cmd_engine.sv

/* Bender.yml */
package:
  name: cmd_engine

sources:
  - src/cmd_pkg.sv
  - src/fifo_sync.sv
  - src/cmd_decode.sv
  - src/alu_execute.sv
  - src/result_pack.sv
  - src/cmd_engine_top.sv
  - target: simulation
    files:
      - sim/cmd_engine_assert.sv
      - sim/tb_cmd_engine.sv
